// ==== common/soc_pkg.sv ====
// --------------------------------------------------------------------------
// Shared bus widths, address map and register offsets for the SoC
// Slave chosen by address bits 31:28, anything from 3 up is unmapped
// Register offsets are byte offsets within a slave's region
// --------------------------------------------------------------------------

package soc_pkg;

    // Bus word types
    typedef logic [31:0] wb_adr_t;
    typedef logic [31:0] wb_dat_t;
    typedef logic [3:0]  wb_sel_t;

    // Address map
    localparam int N_SLAVES       = 3;
    localparam int SLAVE_BOOT_MEM = 0;
    localparam int SLAVE_TIMER    = 1;
    localparam int SLAVE_IRQ_CTRL = 2;

    localparam int BOOT_MEM_WORDS = 256;

    // Timer registers
    localparam logic [3:0] TIMER_LOAD  = 4'h0;
    localparam logic [3:0] TIMER_VALUE = 4'h4;
    localparam logic [3:0] TIMER_CTRL  = 4'h8;
    localparam logic [3:0] TIMER_CLEAR = 4'hC;

    // Interrupt controller registers
    localparam logic [3:0] IRQ_STATUS     = 4'h0;
    localparam logic [3:0] IRQ_RAW        = 4'h4;
    localparam logic [3:0] IRQ_ENABLE_SET = 4'h8;
    localparam logic [3:0] IRQ_ENABLE_CLR = 4'hC;

    // Bit 0 timer, bits 2:1 external inputs
    localparam int N_IRQ = 3;
    typedef logic [N_IRQ-1:0] irq_vec_t;

    typedef enum logic [1:0] {IDLE, BUSY_M0, BUSY_M1} arb_state_t;

endpackage

// ==== logic/wb_arbiter.sv ====
// --------------------------------------------------------------------------
// Two-master arbiter and address decoder for the classic bus
// Master 0 wins ties, a grant lasts until the owner drops cyc
// One idle cycle between grants, unmapped addresses get a one-cycle err
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                           i_clk,
    input  logic                           i_reset,

    input  soc_pkg::wb_adr_t               i_m0_adr,
    input  soc_pkg::wb_sel_t               i_m0_sel,
    input  logic                           i_m0_we,
    input  soc_pkg::wb_dat_t               i_m0_dat,
    input  logic                           i_m0_cyc,
    input  logic                           i_m0_stb,
    output soc_pkg::wb_dat_t               o_m0_dat,
    output logic                           o_m0_ack,
    output logic                           o_m0_err,

    input  soc_pkg::wb_adr_t               i_m1_adr,
    input  soc_pkg::wb_sel_t               i_m1_sel,
    input  logic                           i_m1_we,
    input  soc_pkg::wb_dat_t               i_m1_dat,
    input  logic                           i_m1_cyc,
    input  logic                           i_m1_stb,
    output soc_pkg::wb_dat_t               o_m1_dat,
    output logic                           o_m1_ack,
    output logic                           o_m1_err,

    output soc_pkg::wb_adr_t               o_s_adr,
    output soc_pkg::wb_sel_t               o_s_sel,
    output logic                           o_s_we,
    output soc_pkg::wb_dat_t               o_s_dat,
    output logic [soc_pkg::N_SLAVES-1:0]   o_s_cyc,
    output logic [soc_pkg::N_SLAVES-1:0]   o_s_stb,
    input  soc_pkg::wb_dat_t               i_s0_dat,
    input  soc_pkg::wb_dat_t               i_s1_dat,
    input  soc_pkg::wb_dat_t               i_s2_dat,
    input  logic [soc_pkg::N_SLAVES-1:0]   i_s_ack
);

    soc_pkg::arb_state_t                 state;
    soc_pkg::arb_state_t                 state_nxt;
    logic                                gnt_m0;
    logic                                gnt_m1;
    logic                                gnt_cyc;
    logic                                gnt_stb;
    logic [soc_pkg::N_SLAVES-1:0]        slave_sel;
    logic                                mapped;
    logic                                s_ack;
    soc_pkg::wb_dat_t                    s_dat;
    logic                                err_q;

    // ----------------------------------------------------------------------
    // Grant state machine
    // ----------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            soc_pkg::IDLE: begin
                if (i_m0_cyc && i_m0_stb) begin
                    state_nxt = soc_pkg::BUSY_M0;
                end else if (i_m1_cyc && i_m1_stb) begin
                    state_nxt = soc_pkg::BUSY_M1;
                end
            end
            soc_pkg::BUSY_M0: if (!i_m0_cyc) state_nxt = soc_pkg::IDLE;
            soc_pkg::BUSY_M1: if (!i_m1_cyc) state_nxt = soc_pkg::IDLE;
            default:          state_nxt = soc_pkg::IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= soc_pkg::IDLE;
            err_q <= 1'b0;
        end else begin
            state <= state_nxt;
            // Single err pulse for a granted cycle that hits no slave
            err_q <= gnt_cyc & gnt_stb & ~mapped & ~err_q;
        end
    end

    assign gnt_m0 = (state == soc_pkg::BUSY_M0);
    assign gnt_m1 = (state == soc_pkg::BUSY_M1);

    // Granted master onto the shared slave bus
    assign o_s_adr = gnt_m1 ? i_m1_adr : i_m0_adr;
    assign o_s_sel = gnt_m1 ? i_m1_sel : i_m0_sel;
    assign o_s_we  = gnt_m1 ? i_m1_we  : i_m0_we;
    assign o_s_dat = gnt_m1 ? i_m1_dat : i_m0_dat;
    assign gnt_cyc = (gnt_m0 & i_m0_cyc) | (gnt_m1 & i_m1_cyc);
    assign gnt_stb = (gnt_m0 & i_m0_stb) | (gnt_m1 & i_m1_stb);

    // ----------------------------------------------------------------------
    // Address decode on bits 31:28
    // ----------------------------------------------------------------------
    always_comb begin
        for (int s = 0; s < soc_pkg::N_SLAVES; s++) begin
            slave_sel[s] = (o_s_adr[31:28] == 4'(s));
        end
    end

    assign mapped  = |slave_sel;
    assign o_s_cyc = {soc_pkg::N_SLAVES{gnt_cyc}} & slave_sel;
    assign o_s_stb = {soc_pkg::N_SLAVES{gnt_cyc & gnt_stb}} & slave_sel;

    // Return path from the decoded slave
    always_comb begin
        s_dat = '0;
        if (slave_sel[soc_pkg::SLAVE_BOOT_MEM]) s_dat = i_s0_dat;
        if (slave_sel[soc_pkg::SLAVE_TIMER])    s_dat = i_s1_dat;
        if (slave_sel[soc_pkg::SLAVE_IRQ_CTRL]) s_dat = i_s2_dat;
    end

    assign s_ack    = |(i_s_ack & slave_sel);
    assign o_m0_dat = s_dat;
    assign o_m1_dat = s_dat;
    assign o_m0_ack = gnt_m0 & s_ack;
    assign o_m1_ack = gnt_m1 & s_ack;
    assign o_m0_err = gnt_m0 & err_q;
    assign o_m1_err = gnt_m1 & err_q;

endmodule

// ==== boot_mem/boot_mem.sv ====
// --------------------------------------------------------------------------
// On-chip boot RAM slave, one word wide with byte lane writes
// Contents undefined until written; address bits above the index ignored
// Read data registered, ack one cycle after stb
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module boot_mem (
    input  logic              i_clk,
    input  logic              i_reset,
    input  soc_pkg::wb_adr_t  i_adr,
    input  soc_pkg::wb_sel_t  i_sel,
    input  logic              i_we,
    input  soc_pkg::wb_dat_t  i_dat,
    input  logic              i_cyc,
    input  logic              i_stb,
    output soc_pkg::wb_dat_t  o_dat,
    output logic              o_ack
);

    localparam int AW = $clog2(soc_pkg::BOOT_MEM_WORDS);

    soc_pkg::wb_dat_t  mem [soc_pkg::BOOT_MEM_WORDS];
    logic [AW-1:0]     word_idx;
    logic              access;

    assign word_idx = i_adr[AW+1:2];
    // First cycle of a strobe only
    assign access   = i_cyc & i_stb & ~o_ack;

    always_ff @(posedge i_clk) begin
        if (access) begin
            if (i_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (i_sel[b]) begin
                        mem[word_idx][8*b +: 8] <= i_dat[8*b +: 8];
                    end
                end
            end
            o_dat <= mem[word_idx];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= access;
        end
    end

endmodule

// ==== timer/timer_module.sv ====
// --------------------------------------------------------------------------
// Reloading down-counter slave with a level interrupt
// Counts when CTRL bit 0 is set, reloads at zero and raises the interrupt
// Interrupt held until a write to CLEAR; CTRL and CLEAR use byte lane 0
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module timer_module (
    input  logic              i_clk,
    input  logic              i_reset,
    input  soc_pkg::wb_adr_t  i_adr,
    input  soc_pkg::wb_sel_t  i_sel,
    input  logic              i_we,
    input  soc_pkg::wb_dat_t  i_dat,
    input  logic              i_cyc,
    input  logic              i_stb,
    output soc_pkg::wb_dat_t  o_dat,
    output logic              o_ack,
    output logic              o_timer_int
);

    soc_pkg::wb_dat_t  load;
    soc_pkg::wb_dat_t  load_wr;
    soc_pkg::wb_dat_t  count;
    logic              enable;
    logic              access;
    logic              wr;
    logic [3:0]        offset;

    assign access = i_cyc & i_stb & ~o_ack;
    assign wr     = access & i_we;
    assign offset = {i_adr[3:2], 2'b00};

    // Load value with the selected byte lanes replaced
    always_comb begin
        load_wr = load;
        for (int b = 0; b < 4; b++) begin
            if (i_sel[b]) load_wr[8*b +: 8] = i_dat[8*b +: 8];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            load        <= '0;
            count       <= '0;
            enable      <= 1'b0;
            o_timer_int <= 1'b0;
            o_ack       <= 1'b0;
        end else begin
            o_ack <= access;
            if (enable) begin
                count <= (count == '0) ? load : count - 32'd1;
            end
            if (wr && offset == soc_pkg::TIMER_LOAD) begin
                load  <= load_wr;
                count <= load_wr;
            end
            if (wr && i_sel[0] && offset == soc_pkg::TIMER_CTRL) begin
                enable <= i_dat[0];
            end
            if (wr && i_sel[0] && offset == soc_pkg::TIMER_CLEAR) begin
                o_timer_int <= 1'b0;
            end
            // A new expiry beats a clear in the same cycle
            if (enable && count == '0) begin
                o_timer_int <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (access) begin
            case (offset)
                soc_pkg::TIMER_LOAD:  o_dat <= load;
                soc_pkg::TIMER_VALUE: o_dat <= count;
                soc_pkg::TIMER_CTRL:  o_dat <= {31'd0, enable};
                default:              o_dat <= '0;
            endcase
        end
    end

endmodule

// ==== logic/interrupt_controller.sv ====
// --------------------------------------------------------------------------
// Interrupt controller slave with raw, status and enable registers
// Enables change by writing ones to SET or CLR through byte lane 0
// o_irq is registered, one cycle behind the status
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module interrupt_controller (
    input  logic              i_clk,
    input  logic              i_reset,
    input  soc_pkg::wb_adr_t  i_adr,
    input  soc_pkg::wb_sel_t  i_sel,
    input  logic              i_we,
    input  soc_pkg::wb_dat_t  i_dat,
    input  logic              i_cyc,
    input  logic              i_stb,
    input  logic              i_timer_int,
    input  logic [1:0]        i_ext_irq,
    output soc_pkg::wb_dat_t  o_dat,
    output logic              o_ack,
    output logic              o_irq
);

    soc_pkg::irq_vec_t  raw;
    soc_pkg::irq_vec_t  enable;
    soc_pkg::irq_vec_t  status;
    soc_pkg::irq_vec_t  wr_bits;
    logic               access;
    logic               wr;
    logic [3:0]         offset;

    assign raw     = {i_ext_irq, i_timer_int};
    assign status  = raw & enable;
    assign access  = i_cyc & i_stb & ~o_ack;
    assign wr      = access & i_we & i_sel[0];
    assign offset  = {i_adr[3:2], 2'b00};
    assign wr_bits = i_dat[soc_pkg::N_IRQ-1:0];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            enable <= '0;
            o_irq  <= 1'b0;
            o_ack  <= 1'b0;
        end else begin
            o_ack <= access;
            o_irq <= |status;
            if (wr && offset == soc_pkg::IRQ_ENABLE_SET) begin
                enable <= enable | wr_bits;
            end else if (wr && offset == soc_pkg::IRQ_ENABLE_CLR) begin
                enable <= enable & ~wr_bits;
            end
        end
    end

    // SET and CLR both read back the enable mask
    always_ff @(posedge i_clk) begin
        if (access) begin
            case (offset)
                soc_pkg::IRQ_STATUS: o_dat <= soc_pkg::wb_dat_t'(status);
                soc_pkg::IRQ_RAW:    o_dat <= soc_pkg::wb_dat_t'(raw);
                default:             o_dat <= soc_pkg::wb_dat_t'(enable);
            endcase
        end
    end

endmodule

// ==== logic/system.sv ====
// --------------------------------------------------------------------------
// Top level: two bus masters, arbiter, boot RAM, timer, interrupt controller
// Master ports come from outside; UART interrupts arrive on i_ext_irq
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module system (
    input  logic              i_clk,
    input  logic              i_reset,

    input  soc_pkg::wb_adr_t  i_m0_adr,
    input  soc_pkg::wb_sel_t  i_m0_sel,
    input  logic              i_m0_we,
    input  soc_pkg::wb_dat_t  i_m0_dat,
    input  logic              i_m0_cyc,
    input  logic              i_m0_stb,
    output soc_pkg::wb_dat_t  o_m0_dat,
    output logic              o_m0_ack,
    output logic              o_m0_err,

    input  soc_pkg::wb_adr_t  i_m1_adr,
    input  soc_pkg::wb_sel_t  i_m1_sel,
    input  logic              i_m1_we,
    input  soc_pkg::wb_dat_t  i_m1_dat,
    input  logic              i_m1_cyc,
    input  logic              i_m1_stb,
    output soc_pkg::wb_dat_t  o_m1_dat,
    output logic              o_m1_ack,
    output logic              o_m1_err,

    input  logic [1:0]        i_ext_irq,
    output logic              o_irq
);

    soc_pkg::wb_adr_t                s_adr;
    soc_pkg::wb_sel_t                s_sel;
    logic                            s_we;
    soc_pkg::wb_dat_t                s_dat_w;
    logic [soc_pkg::N_SLAVES-1:0]    s_cyc;
    logic [soc_pkg::N_SLAVES-1:0]    s_stb;
    logic [soc_pkg::N_SLAVES-1:0]    s_ack;
    soc_pkg::wb_dat_t                boot_dat;
    soc_pkg::wb_dat_t                timer_dat;
    soc_pkg::wb_dat_t                irq_dat;
    logic                            timer_int;

    // ----------------------------------------------------------------------
    // Bus arbiter
    // ----------------------------------------------------------------------
    wb_arbiter u_wishbone_arbiter (
        .i_clk     (i_clk),     .i_reset   (i_reset),
        .i_m0_adr  (i_m0_adr),  .i_m0_sel  (i_m0_sel),  .i_m0_we   (i_m0_we),
        .i_m0_dat  (i_m0_dat),  .i_m0_cyc  (i_m0_cyc),  .i_m0_stb  (i_m0_stb),
        .o_m0_dat  (o_m0_dat),  .o_m0_ack  (o_m0_ack),  .o_m0_err  (o_m0_err),
        .i_m1_adr  (i_m1_adr),  .i_m1_sel  (i_m1_sel),  .i_m1_we   (i_m1_we),
        .i_m1_dat  (i_m1_dat),  .i_m1_cyc  (i_m1_cyc),  .i_m1_stb  (i_m1_stb),
        .o_m1_dat  (o_m1_dat),  .o_m1_ack  (o_m1_ack),  .o_m1_err  (o_m1_err),
        .o_s_adr   (s_adr),     .o_s_sel   (s_sel),     .o_s_we    (s_we),
        .o_s_dat   (s_dat_w),   .o_s_cyc   (s_cyc),     .o_s_stb   (s_stb),
        .i_s0_dat  (boot_dat),  .i_s1_dat  (timer_dat), .i_s2_dat  (irq_dat),
        .i_s_ack   (s_ack)
    );

    // ----------------------------------------------------------------------
    // Slaves
    // ----------------------------------------------------------------------
    boot_mem u_boot_mem (
        .i_clk   (i_clk),    .i_reset (i_reset),
        .i_adr   (s_adr),    .i_sel   (s_sel),    .i_we    (s_we),
        .i_dat   (s_dat_w),
        .i_cyc   (s_cyc[soc_pkg::SLAVE_BOOT_MEM]),
        .i_stb   (s_stb[soc_pkg::SLAVE_BOOT_MEM]),
        .o_dat   (boot_dat),
        .o_ack   (s_ack[soc_pkg::SLAVE_BOOT_MEM])
    );

    timer_module u_timer_module (
        .i_clk       (i_clk),    .i_reset (i_reset),
        .i_adr       (s_adr),    .i_sel   (s_sel),    .i_we    (s_we),
        .i_dat       (s_dat_w),
        .i_cyc       (s_cyc[soc_pkg::SLAVE_TIMER]),
        .i_stb       (s_stb[soc_pkg::SLAVE_TIMER]),
        .o_dat       (timer_dat),
        .o_ack       (s_ack[soc_pkg::SLAVE_TIMER]),
        .o_timer_int (timer_int)
    );

    interrupt_controller u_interrupt_controller (
        .i_clk       (i_clk),    .i_reset (i_reset),
        .i_adr       (s_adr),    .i_sel   (s_sel),    .i_we    (s_we),
        .i_dat       (s_dat_w),
        .i_cyc       (s_cyc[soc_pkg::SLAVE_IRQ_CTRL]),
        .i_stb       (s_stb[soc_pkg::SLAVE_IRQ_CTRL]),
        .i_timer_int (timer_int),
        .i_ext_irq   (i_ext_irq),
        .o_dat       (irq_dat),
        .o_ack       (s_ack[soc_pkg::SLAVE_IRQ_CTRL]),
        .o_irq       (o_irq)
    );

endmodule

// ==== verif/system_assert.sv ====
// --------------------------------------------------------------------------
// Bus handshake and interrupt checks bound into the system top level
// Sampled on the falling edge, where the masters change their requests
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module system_assert (
    input logic i_clk,
    input logic i_reset,
    input logic i_m0_cyc,
    input logic i_m0_stb,
    input logic i_m0_ack,
    input logic i_m0_err,
    input logic i_m1_cyc,
    input logic i_m1_stb,
    input logic i_m1_ack,
    input logic i_m1_err,
    input logic i_irq
);

    // Master 0
    a_m0_excl: assert property (@(negedge i_clk) disable iff (i_reset)
        !(i_m0_ack && i_m0_err)) else $error("master 0 ack and err high together");
    a_m0_req: assert property (@(negedge i_clk) disable iff (i_reset)
        i_m0_ack |-> (i_m0_cyc && i_m0_stb)) else $error("master 0 ack without a request");
    a_m0_pulse: assert property (@(negedge i_clk) disable iff (i_reset)
        i_m0_ack |=> !i_m0_ack) else $error("master 0 ack longer than one cycle");

    // Master 1
    a_m1_excl: assert property (@(negedge i_clk) disable iff (i_reset)
        !(i_m1_ack && i_m1_err)) else $error("master 1 ack and err high together");
    a_m1_req: assert property (@(negedge i_clk) disable iff (i_reset)
        i_m1_ack |-> (i_m1_cyc && i_m1_stb)) else $error("master 1 ack without a request");
    a_m1_pulse: assert property (@(negedge i_clk) disable iff (i_reset)
        i_m1_ack |=> !i_m1_ack) else $error("master 1 ack longer than one cycle");

    a_irq_reset: assert property (@(negedge i_clk)
        i_reset |=> !i_irq) else $error("interrupt line high after reset");

endmodule

bind system system_assert u_system_assert (
    .i_clk    (i_clk),    .i_reset  (i_reset),
    .i_m0_cyc (i_m0_cyc), .i_m0_stb (i_m0_stb), .i_m0_ack (o_m0_ack), .i_m0_err (o_m0_err),
    .i_m1_cyc (i_m1_cyc), .i_m1_stb (i_m1_stb), .i_m1_ack (o_m1_ack), .i_m1_err (o_m1_err),
    .i_irq    (o_irq)
);

// ==== verif/tb_system.sv ====
// --------------------------------------------------------------------------
// Testbench for the two-master bus system
// Both master ports driven on the falling clock edge, outputs sampled there
// Boot memory expectations come from a byte-lane model built with the table
// Run ends at a cycle limit scaled by the table length
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_system;

    localparam int N_ENTRIES      = 11;
    localparam int TIMEOUT_CYCLES = 40 * N_ENTRIES + 400;
    localparam int LOAD_VAL       = 40;
    localparam int MODEL_AW       = $clog2(soc_pkg::BOOT_MEM_WORDS);

    logic                         i_clk;
    logic                         i_reset;
    soc_pkg::wb_adr_t [1:0]       m_adr;
    soc_pkg::wb_sel_t [1:0]       m_sel;
    soc_pkg::wb_dat_t [1:0]       m_wdat;
    logic [1:0]                   m_we;
    logic [1:0]                   m_cyc;
    logic [1:0]                   m_stb;
    wire  [1:0][31:0]             m_rdat;
    wire  [1:0]                   m_ack;
    wire  [1:0]                   m_err;
    logic [1:0]                   i_ext_irq;
    wire                          o_irq;

    int                           errors = 0;
    int                           checks = 0;
    int                           cycles = 0;
    int                           seed = 3385;

    // Stimulus table, one column per field
    int                           t_master [N_ENTRIES];
    soc_pkg::wb_adr_t             t_adr    [N_ENTRIES];
    soc_pkg::wb_sel_t             t_sel    [N_ENTRIES];
    logic                         t_we     [N_ENTRIES];
    soc_pkg::wb_dat_t             t_wdat   [N_ENTRIES];
    soc_pkg::wb_dat_t             t_exp    [N_ENTRIES];
    logic                         t_err    [N_ENTRIES];
    soc_pkg::wb_dat_t             model    [soc_pkg::BOOT_MEM_WORDS];

    system DUT (
        .i_clk     (i_clk),      .i_reset   (i_reset),
        .i_m0_adr  (m_adr[0]),   .i_m0_sel  (m_sel[0]),   .i_m0_we   (m_we[0]),
        .i_m0_dat  (m_wdat[0]),  .i_m0_cyc  (m_cyc[0]),   .i_m0_stb  (m_stb[0]),
        .o_m0_dat  (m_rdat[0]),  .o_m0_ack  (m_ack[0]),   .o_m0_err  (m_err[0]),
        .i_m1_adr  (m_adr[1]),   .i_m1_sel  (m_sel[1]),   .i_m1_we   (m_we[1]),
        .i_m1_dat  (m_wdat[1]),  .i_m1_cyc  (m_cyc[1]),   .i_m1_stb  (m_stb[1]),
        .o_m1_dat  (m_rdat[1]),  .o_m1_ack  (m_ack[1]),   .o_m1_err  (m_err[1]),
        .i_ext_irq (i_ext_irq),  .o_irq     (o_irq)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    always @(posedge i_clk) cycles <= cycles + 1;

    initial begin
        wait (cycles >= TIMEOUT_CYCLES);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at %0t ns: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
        end
    endtask

    function automatic soc_pkg::wb_adr_t reg_adr(input int slave, input logic [3:0] off);
        return {4'(slave), 24'd0, off};
    endfunction

    // One table row with random write data and model read data
    task automatic add_entry(input int idx, input int m, input soc_pkg::wb_adr_t adr,
                             input soc_pkg::wb_sel_t sel, input logic we,
                             input logic exp_err);
        logic [MODEL_AW-1:0] w;
        w = adr[MODEL_AW+1:2];
        t_master[idx] = m;
        t_adr[idx]    = adr;
        t_sel[idx]    = sel;
        t_we[idx]     = we;
        t_err[idx]    = exp_err;
        t_wdat[idx]   = $random(seed);
        if (!exp_err && we) begin
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) model[w][8*b +: 8] = t_wdat[idx][8*b +: 8];
            end
        end
        t_exp[idx] = exp_err ? 32'd0 : model[w];
    endtask

    // One bus cycle on master m held until ack or err
    task automatic bus_access(input int m, input soc_pkg::wb_adr_t adr,
                              input soc_pkg::wb_sel_t sel, input logic we,
                              input soc_pkg::wb_dat_t dat, output soc_pkg::wb_dat_t rdat,
                              output logic got_ack, output logic got_err,
                              output int end_cycle);
        @(negedge i_clk);
        m_adr[m]  = adr;
        m_sel[m]  = sel;
        m_we[m]   = we;
        m_wdat[m] = dat;
        m_cyc[m]  = 1'b1;
        m_stb[m]  = 1'b1;
        do begin
            @(negedge i_clk);
        end while (!m_ack[m] && !m_err[m]);
        rdat      = m_rdat[m];
        got_ack   = m_ack[m];
        got_err   = m_err[m];
        end_cycle = cycles;
        m_cyc[m]  = 1'b0;
        m_stb[m]  = 1'b0;
        m_we[m]   = 1'b0;
    endtask

    task automatic write_reg(input int m, input soc_pkg::wb_adr_t adr,
                             input soc_pkg::wb_dat_t dat);
        soc_pkg::wb_dat_t rdat;
        logic             ack;
        logic             err;
        int               c;
        bus_access(m, adr, 4'hF, 1'b1, dat, rdat, ack, err, c);
        check_value($sformatf("m%0d_ack", m), 32'(ack), 1);
    endtask

    task automatic read_reg(input int m, input soc_pkg::wb_adr_t adr,
                            output soc_pkg::wb_dat_t rdat);
        logic ack;
        logic err;
        int   c;
        bus_access(m, adr, 4'hF, 1'b0, 32'd0, rdat, ack, err, c);
        check_value($sformatf("m%0d_ack", m), 32'(ack), 1);
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        soc_pkg::wb_dat_t rdat;
        soc_pkg::wb_dat_t rd0;
        soc_pkg::wb_dat_t rd1;
        logic             ack0;
        logic             ack1;
        logic             err0;
        logic             err1;
        int               c0;
        int               c1;

        i_reset   = 1'b1;
        m_adr     = '0;
        m_sel     = '0;
        m_wdat    = '0;
        m_we      = '0;
        m_cyc     = '0;
        m_stb     = '0;
        i_ext_irq = 2'b00;

        // Full words first, then partial lanes, alias and unmapped accesses
        add_entry(0,  0, 32'h0000_0000, 4'hF, 1'b1, 1'b0);
        add_entry(1,  1, 32'h0000_0004, 4'hF, 1'b1, 1'b0);
        add_entry(2,  0, 32'h0000_0014, 4'hF, 1'b1, 1'b0);
        add_entry(3,  1, 32'h0000_0000, 4'h3, 1'b1, 1'b0);
        add_entry(4,  0, 32'h0000_0004, 4'h8, 1'b1, 1'b0);
        add_entry(5,  1, 32'h0000_0014, 4'h5, 1'b1, 1'b0);
        add_entry(6,  0, 32'h0000_0000, 4'hF, 1'b0, 1'b0);
        add_entry(7,  1, 32'h0000_0004, 4'hF, 1'b0, 1'b0);
        add_entry(8,  0, 32'h0000_0414, 4'hF, 1'b0, 1'b0);
        add_entry(9,  1, 32'h3000_0000, 4'hF, 1'b0, 1'b1);
        add_entry(10, 0, 32'hF000_0010, 4'hF, 1'b1, 1'b1);

        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;

        for (int i = 0; i < N_ENTRIES; i++) begin
            bus_access(t_master[i], t_adr[i], t_sel[i], t_we[i], t_wdat[i],
                       rdat, ack0, err0, c0);
            check_value($sformatf("m%0d_err", t_master[i]), 32'(err0), 32'(t_err[i]));
            check_value($sformatf("m%0d_ack", t_master[i]), 32'(ack0), 32'(!t_err[i]));
            if (!t_we[i] && !t_err[i]) begin
                check_value($sformatf("m%0d_dat", t_master[i]), rdat, t_exp[i]);
            end
        end

        // Both masters request in the same cycle
        fork
            bus_access(0, 32'h0000_0000, 4'hF, 1'b0, 32'd0, rd0, ack0, err0, c0);
            bus_access(1, 32'h0000_0004, 4'hF, 1'b0, 32'd0, rd1, ack1, err1, c1);
        join
        check_value("m0_ack", 32'(ack0), 1);
        check_value("m1_ack", 32'(ack1), 1);
        check_value("m0_err", 32'(err0), 0);
        check_value("m1_err", 32'(err1), 0);
        check_value("m0_dat", rd0, model[0]);
        check_value("m1_dat", rd1, model[1]);
        check_value("m0_ack_before_m1_ack", 32'(c0 < c1), 1);

        // ------------------------------------------------------------------
        // Timer
        // ------------------------------------------------------------------
        write_reg(0, reg_adr(soc_pkg::SLAVE_TIMER, soc_pkg::TIMER_LOAD), LOAD_VAL);
        write_reg(0, reg_adr(soc_pkg::SLAVE_TIMER, soc_pkg::TIMER_CTRL), 32'h1);
        repeat (4) begin
            read_reg(1, reg_adr(soc_pkg::SLAVE_TIMER, soc_pkg::TIMER_VALUE), rdat);
            check_value("timer_value_within_load", 32'(rdat <= LOAD_VAL), 1);
        end
        repeat (LOAD_VAL + 2) @(negedge i_clk);
        read_reg(0, reg_adr(soc_pkg::SLAVE_IRQ_CTRL, soc_pkg::IRQ_RAW), rdat);
        check_value("irq_raw", rdat, 32'h1);
        // Stop the counter so it cannot expire again before the clear
        write_reg(0, reg_adr(soc_pkg::SLAVE_TIMER, soc_pkg::TIMER_CTRL), 32'h0);
        write_reg(0, reg_adr(soc_pkg::SLAVE_TIMER, soc_pkg::TIMER_CLEAR), 32'h1);
        read_reg(0, reg_adr(soc_pkg::SLAVE_IRQ_CTRL, soc_pkg::IRQ_RAW), rdat);
        check_value("irq_raw", rdat, 32'h0);

        // ------------------------------------------------------------------
        // Interrupt masking
        // ------------------------------------------------------------------
        // Ext bit 0 is source bit 1
        @(negedge i_clk);
        i_ext_irq = 2'b01;
        repeat (3) begin
            @(negedge i_clk);
            check_value("o_irq", 32'(o_irq), 0);
        end
        write_reg(1, reg_adr(soc_pkg::SLAVE_IRQ_CTRL, soc_pkg::IRQ_ENABLE_SET), 32'h2);
        read_reg(1, reg_adr(soc_pkg::SLAVE_IRQ_CTRL, soc_pkg::IRQ_STATUS), rdat);
        check_value("irq_status", rdat, 32'h2);
        check_value("o_irq", 32'(o_irq), 1);
        write_reg(0, reg_adr(soc_pkg::SLAVE_IRQ_CTRL, soc_pkg::IRQ_ENABLE_CLR), 32'h2);
        repeat (2) @(negedge i_clk);
        check_value("o_irq", 32'(o_irq), 0);
        i_ext_irq = 2'b00;

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== all.f ====
common/soc_pkg.sv
logic/wb_arbiter.sv
boot_mem/boot_mem.sv
timer/timer_module.sv
logic/interrupt_controller.sv
logic/system.sv
verif/system_assert.sv
verif/tb_system.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the bus system testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_system -f all.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation passed"
exit 0
